/* verif/weight_rotator_input.txt */
# geometry line: g kw2 cin_1 cols_1 xn_1 (decimal), then 2 + (2*kw2+1)*(cin_1+1) beats
# beat line: one 32-bit hex word, lane 0 in the low byte
g 1 0 2 1
c0a00001
c0a00002
1a2a3a4a
5a6a7a8a
9aaabaca
g 0 1 1 0
c0b00001
c0b00002
1b2b3b4b
5b6b7b8b
g 2 1 3 0
c0c00001
c0c00002
01c102c1
03c104c1
05c106c1
07c108c1
09c10ac1
0bc10cc1
0dc10ec1
0fc110c1
11c112c1
13c114c1
g 0 0 4 0
c0d00001
c0d00002
7d6d5d4d

/* tb.f */
hdl/rot_pkg.sv
hdl/weight_write_ctrl.sv
hdl/weight_bank_ram.sv
hdl/weight_cfg_regs.sv
hdl/weight_read_ctrl.sv
hdl/weight_out_skid.sv
hdl/weight_rotator.sv
verif/weight_rotator_tb.sv

/* Makefile */
# Verilator flow for the weight rotator testbench, run from the project root

TOP := weight_rotator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/weight_rotator_tb.sv */
/*
  Testbench for weight_rotator. Weight sets are read from verif/weight_rotator_input.txt,
  relative to the project root. Slave gaps and master back-pressure are random (fixed seed).
*/
`default_nettype none

module weight_rotator_tb;

  localparam int COLS         = 4;
  localparam int WORD_W       = 8;
  localparam int DEPTH        = 64;
  localparam int CONFIG_BEATS = 2;
  localparam int GEOM_W       = 20;
  localparam int TIMEOUT      = 1000;

  logic                   aclk;
  logic                   aresetn;
  logic                   i_s_tvalid;
  logic                   o_s_tready;
  logic [COLS*WORD_W-1:0] i_s_tdata;
  logic                   i_s_tlast;
  logic [GEOM_W-1:0]      i_s_tuser;
  logic                   o_m_tvalid;
  logic                   i_m_tready;
  logic [COLS*WORD_W-1:0] o_m_tdata;
  logic                   o_m_tlast;
  logic [6:0]             o_m_tuser;

  // sets as loaded from the data file
  logic [COLS*WORD_W-1:0] words [$];
  logic [GEOM_W-1:0]      geom_q [$];
  int kw2_q [$];
  int cin_q [$];
  int cols_q [$];
  int xn_q [$];
  int base_q [$];
  int nsets = 0;
  int errors = 0;
  int beats_checked = 0;
  int sets_written = 0;
  int sets_read = 0;
  int full_stall = 0;
  bit timed_out = 1'b0;

  weight_rotator #(
    .COLS(COLS), .WORD_W(WORD_W), .DEPTH(DEPTH), .CONFIG_BEATS(CONFIG_BEATS)
  ) dut (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .i_s_tuser  (i_s_tuser),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tuser  (o_m_tuser)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic load_sets();
    int fd;
    int n;
    int kw2;
    int cin_1;
    int cols_1;
    int xn_1;
    int need;
    logic [COLS*WORD_W-1:0] w;
    string line;
    need = 0;
    fd = $fopen("verif/weight_rotator_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open verif/weight_rotator_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n < 2 || line[0] == "#") continue;
      if (line[0] == "g") begin
        n = $sscanf(line, "g %d %d %d %d", kw2, cin_1, cols_1, xn_1);
        kw2_q.push_back(kw2);
        cin_q.push_back(cin_1);
        cols_q.push_back(cols_1);
        xn_q.push_back(xn_1);
        base_q.push_back(words.size());
        // tuser layout {xn_1, cols_1, cin_1, kw2}
        geom_q.push_back({4'(xn_1), 8'(cols_1), 6'(cin_1), 2'(kw2)});
        need += CONFIG_BEATS + (2 * kw2 + 1) * (cin_1 + 1);
      end else begin
        n = $sscanf(line, "%h", w);
        words.push_back(w);
      end
    end
    $fclose(fd);
    nsets = kw2_q.size();
    if (words.size() != need) begin
      errors++;
      $display("input file holds %0d beats but its geometry needs %0d", words.size(), need);
    end
  endtask

  task automatic send_sets();
    int nb;
    int waited;
    for (int s = 0; s < nsets && !timed_out; s++) begin
      nb = CONFIG_BEATS + (2 * kw2_q[s] + 1) * (cin_q[s] + 1);
      for (int b = 0; b < nb && !timed_out; b++) begin
        if ($urandom_range(3) == 0) begin
          i_s_tvalid <= 1'b0;
          @(posedge aclk);
        end
        i_s_tvalid <= 1'b1;
        i_s_tdata  <= words[base_q[s] + b];
        i_s_tlast  <= (b == nb - 1);
        i_s_tuser  <= (b == nb - 1) ? geom_q[s] : '0;
        waited = 0;
        @(negedge aclk);
        while (!o_s_tready && !timed_out && waited < TIMEOUT) begin
          @(negedge aclk);
          waited++;
        end
        if (!o_s_tready && !timed_out) begin
          timed_out = 1'b1;
          $display("timeout: o_s_tready stayed low on beat %0d of set %0d", b, s);
        end
        @(posedge aclk);
        if (b == nb - 1) sets_written++;
      end
    end
    i_s_tvalid <= 1'b0;
    i_s_tlast  <= 1'b0;
  endtask

  // returns at the negedge before a master handshake
  task automatic wait_beat(output bit ok);
    int waited;
    bit stalled;
    logic [COLS*WORD_W-1:0] held_data;
    logic [6:0] held_user;
    logic held_last;
    waited = 0;
    stalled = 1'b0;
    ok = 1'b0;
    while (!ok && !timed_out && waited < TIMEOUT) begin
      @(posedge aclk);
      i_m_tready <= ($urandom_range(3) != 0);
      @(negedge aclk);
      assert (!(o_m_tvalid && sets_written == 0)) else begin
        errors++;
        $display("Fail t=%0t o_m_tvalid exp 0 got %b (no set written yet)",
                 $time, o_m_tvalid);
      end
      if (stalled) begin
        assert (o_m_tvalid && o_m_tdata == held_data && o_m_tuser == held_user &&
                o_m_tlast == held_last) else begin
          errors++;
          $display("Fail t=%0t o_m_tdata/o_m_tuser exp %h/%b held got %h/%b valid %b",
                   $time, held_data, held_user, o_m_tdata, o_m_tuser, o_m_tvalid);
        end
      end
      stalled   = o_m_tvalid && !i_m_tready;
      held_data = o_m_tdata;
      held_user = o_m_tuser;
      held_last = o_m_tlast;
      ok = o_m_tvalid && i_m_tready;
      waited++;
    end
  endtask

  task automatic check_sets();
    int nk;
    int total;
    int i;
    int col;
    bit ok;
    logic [COLS*WORD_W-1:0] exp_data;
    logic [6:0] exp_user;
    for (int s = 0; s < nsets; s++) begin
      nk = (2 * kw2_q[s] + 1) * (cin_q[s] + 1);
      total = CONFIG_BEATS + nk * (cols_q[s] + 1) * (xn_q[s] + 1);
      for (int k = 0; k < total; k++) begin
        wait_beat(ok);
        if (!ok) begin
          timed_out = 1'b1;
          $display("timeout: no output beat %0d of set %0d", k, s);
          return;
        end
        if (k < CONFIG_BEATS) begin
          exp_data = words[base_q[s] + k];
          exp_user = {1'b1, 4'b0000, 2'(kw2_q[s])};
        end else begin
          // position within the column pass and the column it belongs to
          i   = (k - CONFIG_BEATS) % nk;
          col = ((k - CONFIG_BEATS) / nk) % (cols_q[s] + 1);
          exp_data = words[base_q[s] + CONFIG_BEATS + i];
          exp_user = {1'b0, i == 0, i == nk - 1, (cols_q[s] - col) < kw2_q[s],
                      col == cols_q[s], 2'(kw2_q[s])};
        end
        assert (o_m_tdata == exp_data) else begin
          errors++;
          $display("Fail t=%0t o_m_tdata exp %h got %h (set %0d beat %0d)",
                   $time, exp_data, o_m_tdata, s, k);
        end
        assert (o_m_tuser == exp_user) else begin
          errors++;
          $display("Fail t=%0t o_m_tuser exp %b got %b (set %0d beat %0d)",
                   $time, exp_user, o_m_tuser, s, k);
        end
        assert (o_m_tlast == (k == total - 1)) else begin
          errors++;
          $display("Fail t=%0t o_m_tlast exp %b got %b (set %0d beat %0d)",
                   $time, k == total - 1, o_m_tlast, s, k);
        end
        beats_checked++;
      end
      sets_read++;
    end
  endtask

  // both banks hold unread sets, so the slave must be stalled
  always @(negedge aclk) begin
    if (aresetn && (sets_written - sets_read >= 2)) begin
      assert (!o_s_tready) else begin
        errors++;
        $display("Fail t=%0t o_s_tready exp 0 got %b", $time, o_s_tready);
      end
      if (i_s_tvalid) full_stall++;
    end
  end

  initial begin
    void'($urandom(32'h270b));
    aresetn    = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tlast  = 1'b0;
    i_s_tuser  = '0;
    i_m_tready = 1'b0;
    load_sets();
    for (int c = 0; c < 10; c++) begin
      @(negedge aclk);
      assert (!o_m_tvalid) else begin
        errors++;
        $display("Fail t=%0t o_m_tvalid exp 0 got %b", $time, o_m_tvalid);
      end
    end
    @(posedge aclk);
    aresetn <= 1'b1;
    fork
      send_sets();
      check_sets();
    join
    if (nsets >= 3) begin
      assert (full_stall > 0) else begin
        errors++;
        $display("slave never stalled while both banks were full");
      end
    end
    $display("summary: %0d sets, %0d beats checked, %0d errors, %0d timeouts",
             sets_read, beats_checked, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/weight_rotator.sv */
/*
  Double-buffered weight store: AXI-Stream slave in, COLS-lane AXI-Stream master out.
  Geometry on i_s_tuser is sampled on the last beat only. A third set stalls the
  slave until the reader releases a bank.
*/
`default_nettype none

module weight_rotator #(
  parameter int COLS         = 4,
  parameter int WORD_W       = 8,
  parameter int DEPTH        = 64,
  parameter int CONFIG_BEATS = 2
) (
  input  wire                   aclk,
  input  wire                   aresetn,
  input  wire                   i_s_tvalid,
  output logic                  o_s_tready,
  input  wire [COLS*WORD_W-1:0] i_s_tdata,
  input  wire                   i_s_tlast,
  input  wire [rot_pkg::KW2_W+rot_pkg::CIN_W+rot_pkg::COLS_W+rot_pkg::XN_W-1:0] i_s_tuser,
  output logic                  o_m_tvalid,
  input  wire                   i_m_tready,
  output logic [COLS*WORD_W-1:0] o_m_tdata,
  output logic                  o_m_tlast,
  output rot_pkg::weight_user_t o_m_tuser
);
  import rot_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);

  logic                   wen;
  logic [ADDR_W-1:0]      waddr;
  logic                   wbank;
  logic                   cfg_wen;
  logic [1:0]             bank_full;
  logic                   read_done;
  logic                   rbank;
  logic                   ren;
  logic                   ren_q;
  logic [ADDR_W-1:0]      raddr;
  logic [COLS*WORD_W-1:0] rdata;
  logic                   slot_free;
  logic                   pop;
  weight_user_t           rd_user;
  logic                   rd_last;
  logic [KW2_W-1:0]       kw2;
  logic [CIN_W-1:0]       cin_1;
  logic [COLS_W-1:0]      cols_1;
  logic [XN_W-1:0]        xn_1;
  logic [ADDR_W-1:0]      addr_max;

  weight_write_ctrl #(.DEPTH(DEPTH)) u_write_ctrl (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_s_tvalid  (i_s_tvalid),
    .i_s_tlast   (i_s_tlast),
    .o_s_tready  (o_s_tready),
    .o_wen       (wen),
    .o_waddr     (waddr),
    .o_wbank     (wbank),
    .o_cfg_wen   (cfg_wen),
    .i_read_done (read_done),
    .i_done_bank (rbank),
    .o_bank_full (bank_full)
  );

  weight_bank_ram #(.COLS(COLS), .WORD_W(WORD_W), .DEPTH(DEPTH)) u_ram (
    .aclk    (aclk),
    .i_wen   (wen),
    .i_wbank (wbank),
    .i_waddr (waddr),
    .i_wdata (i_s_tdata),
    .i_ren   (ren),
    .i_rbank (rbank),
    .i_raddr (raddr),
    .o_rdata (rdata)
  );

  weight_cfg_regs #(.DEPTH(DEPTH), .CONFIG_BEATS(CONFIG_BEATS)) u_cfg_regs (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_wen      (cfg_wen),
    .i_wbank    (wbank),
    .i_geom     (i_s_tuser),
    .i_rbank    (rbank),
    .o_kw2      (kw2),
    .o_cin_1    (cin_1),
    .o_cols_1   (cols_1),
    .o_xn_1     (xn_1),
    .o_addr_max (addr_max)
  );

  weight_read_ctrl #(.DEPTH(DEPTH), .CONFIG_BEATS(CONFIG_BEATS)) u_read_ctrl (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_bank_full (bank_full),
    .o_read_done (read_done),
    .o_rbank     (rbank),
    .o_ren       (ren),
    .o_raddr     (raddr),
    .i_slot_free (slot_free),
    .i_pop       (pop),
    .o_user      (rd_user),
    .o_last      (rd_last),
    .i_kw2       (kw2),
    .i_cin_1     (cin_1),
    .i_cols_1    (cols_1),
    .i_xn_1      (xn_1),
    .i_addr_max  (addr_max)
  );

  // valid follows the RAM read by one cycle
  always_ff @(posedge aclk) begin
    if (!aresetn) ren_q <= 1'b0;
    else ren_q <= ren;
  end

  weight_out_skid #(.COLS(COLS), .WORD_W(WORD_W)) u_out_skid (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_valid     (ren_q),
    .i_data      (rdata),
    .i_user      (rd_user),
    .i_last      (rd_last),
    .o_slot_free (slot_free),
    .o_pop       (pop),
    .o_m_tvalid  (o_m_tvalid),
    .i_m_tready  (i_m_tready),
    .o_m_tdata   (o_m_tdata),
    .o_m_tuser   (o_m_tuser),
    .o_m_tlast   (o_m_tlast)
  );

endmodule

`default_nettype wire

/* hdl/weight_out_skid.sv */
/*
  Two-entry output FIFO behind the one-cycle RAM read. o_slot_free counts the item
  still in the RAM pipeline, so an issued read always finds room.
*/
`default_nettype none

module weight_out_skid #(
  parameter int COLS   = 4,
  parameter int WORD_W = 8
) (
  input  wire                        aclk,
  input  wire                        aresetn,
  input  wire                        i_valid,
  input  wire [COLS*WORD_W-1:0]      i_data,
  input  wire rot_pkg::weight_user_t i_user,
  input  wire                        i_last,
  output logic                       o_slot_free,
  output logic                       o_pop,
  output logic                       o_m_tvalid,
  input  wire                        i_m_tready,
  output logic [COLS*WORD_W-1:0]     o_m_tdata,
  output rot_pkg::weight_user_t      o_m_tuser,
  output logic                       o_m_tlast
);
  import rot_pkg::*;

  logic [COLS*WORD_W-1:0] data_q [2];
  weight_user_t           user_q [2];
  logic                   last_q [2];
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [1:0]             count;

  assign o_m_tvalid  = (count != 2'd0);
  assign o_pop       = o_m_tvalid && i_m_tready;
  assign o_slot_free = (count + {1'b0, i_valid} - {1'b0, o_pop}) < 2'd2;

  // head entry holds until popped
  assign o_m_tdata = data_q[rd_ptr];
  assign o_m_tuser = user_q[rd_ptr];
  assign o_m_tlast = last_q[rd_ptr];

  always_ff @(posedge aclk) begin
    if (i_valid) begin
      data_q[wr_ptr] <= i_data;
      user_q[wr_ptr] <= i_user;
      last_q[wr_ptr] <= i_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= '0;
    end else begin
      if (i_valid) wr_ptr <= ~wr_ptr;
      if (o_pop) rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, i_valid} - {1'b0, o_pop};
    end
  end

  a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
    !(count == 2'd2 && i_valid && !o_pop));

endmodule

`default_nettype wire

/* hdl/weight_read_ctrl.sv */
/*
  Read side: streams the config entries once, then cycles the kernel entries per
  output column and image. CONFIG_BEATS must be at least 1. Flags are registered
  with the address so they line up with the RAM data one cycle later.
*/
`default_nettype none

module weight_read_ctrl #(
  parameter  int DEPTH        = 64,
  parameter  int CONFIG_BEATS = 2,
  localparam int ADDR_W       = $clog2(DEPTH)
) (
  input  wire                         aclk,
  input  wire                         aresetn,
  input  wire [1:0]                   i_bank_full,
  output logic                        o_read_done,
  output logic                        o_rbank,
  output logic                        o_ren,
  output logic [ADDR_W-1:0]           o_raddr,
  input  wire                         i_slot_free,
  input  wire                         i_pop,
  output rot_pkg::weight_user_t       o_user,
  output logic                        o_last,
  input  wire [rot_pkg::KW2_W-1:0]    i_kw2,
  input  wire [rot_pkg::CIN_W-1:0]    i_cin_1,
  input  wire [rot_pkg::COLS_W-1:0]   i_cols_1,
  input  wire [rot_pkg::XN_W-1:0]     i_xn_1,
  input  wire [ADDR_W-1:0]            i_addr_max
);
  import rot_pkg::*;

  rd_state_e         state;
  logic [ADDR_W-1:0] addr;
  logic [KW2_W:0]    kw_cnt;
  logic [CIN_W-1:0]  cin_cnt;
  logic [COLS_W-1:0] col_cnt;
  logic [XN_W-1:0]   xn_cnt;
  logic [COLS_W-1:0] cols_left;
  logic [1:0]        infl;
  logic              issue_done;
  logic              in_config;
  logic              cfg_last;
  logic              kw_last;
  logic              cin_last;
  logic              col_last;
  logic              xn_last;
  logic              pop_last;

  assign in_config = (state == rd_idle) || (state == rd_pass_config);
  assign cfg_last  = (addr == ADDR_W'(CONFIG_BEATS - 1));
  assign kw_last   = (kw_cnt == {i_kw2, 1'b0});
  assign cin_last  = (cin_cnt == i_cin_1);
  assign col_last  = (col_cnt == i_cols_1);
  assign xn_last   = (xn_cnt == i_xn_1);
  assign cols_left = i_cols_1 - col_cnt;

  // first address goes out in idle already, so valid shows two cycles after full
  assign o_ren = i_slot_free &&
                 (((state == rd_idle) && i_bank_full[o_rbank]) ||
                  (state == rd_pass_config) ||
                  ((state == rd_read) && !issue_done));
  assign o_raddr     = addr;
  assign o_read_done = (state == rd_switch);

  // last beat of the set leaves the skid buffer
  assign pop_last = issue_done && i_pop && (infl == 2'd1);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= rd_idle;
      o_rbank <= 1'b0;
    end else begin
      unique case (state)
        rd_idle: begin
          if (i_bank_full[o_rbank]) state <= (o_ren && cfg_last) ? rd_read : rd_pass_config;
        end
        rd_pass_config: if (o_ren && cfg_last) state <= rd_read;
        rd_read:        if (pop_last) state <= rd_switch;
        rd_switch: begin
          o_rbank <= ~o_rbank;
          state   <= rd_idle;
        end
        default: state <= rd_idle;
      endcase
    end
  end

  // address and nested position counters, kw innermost
  always_ff @(posedge aclk) begin
    if (!aresetn || state == rd_switch) begin
      addr       <= '0;
      kw_cnt     <= '0;
      cin_cnt    <= '0;
      col_cnt    <= '0;
      xn_cnt     <= '0;
      issue_done <= 1'b0;
    end else if (o_ren) begin
      if (in_config) begin
        addr <= addr + 1'b1;
      end else begin
        addr   <= (addr == i_addr_max) ? ADDR_W'(CONFIG_BEATS) : addr + 1'b1;
        kw_cnt <= kw_last ? '0 : kw_cnt + 1'b1;
        if (kw_last) begin
          cin_cnt <= cin_last ? '0 : cin_cnt + 1'b1;
          if (cin_last) begin
            col_cnt <= col_last ? '0 : col_cnt + 1'b1;
            if (col_last) begin
              xn_cnt     <= xn_last ? '0 : xn_cnt + 1'b1;
              issue_done <= xn_last;
            end
          end
        end
      end
    end
  end

  // items issued but not yet popped, at most two
  always_ff @(posedge aclk) begin
    if (!aresetn) infl <= '0;
    else infl <= infl + {1'b0, o_ren} - {1'b0, i_pop};
  end

  // flags captured with the address
  always_ff @(posedge aclk) begin
    if (o_ren) begin
      o_user.is_config      <= in_config;
      o_user.is_w_first_clk <= !in_config && (kw_cnt == '0) && (cin_cnt == '0);
      o_user.is_cin_last    <= !in_config && kw_last && cin_last;
      o_user.is_w_first_kw2 <= !in_config && (cols_left < COLS_W'(i_kw2));
      o_user.is_w_last      <= !in_config && col_last;
      o_user.kw2            <= i_kw2;
      o_last                <= !in_config && kw_last && cin_last && col_last && xn_last;
    end
  end

  a_read_full_bank: assert property (@(posedge aclk) disable iff (!aresetn)
    (o_ren || o_read_done) |-> i_bank_full[o_rbank]);

endmodule

`default_nettype wire

/* hdl/weight_cfg_regs.sv */
/*
  Geometry of each bank, captured on the last slave beat of a set.
  The read bank's geometry and its last kernel address are presented combinationally.
*/
`default_nettype none

module weight_cfg_regs #(
  parameter  int DEPTH        = 64,
  parameter  int CONFIG_BEATS = 2,
  localparam int ADDR_W       = $clog2(DEPTH)
) (
  input  wire                                     aclk,
  input  wire                                     aresetn,
  input  wire                                     i_wen,
  input  wire                                     i_wbank,
  input  wire [rot_pkg::KW2_W+rot_pkg::CIN_W+rot_pkg::COLS_W+rot_pkg::XN_W-1:0] i_geom,
  input  wire                                     i_rbank,
  output logic [rot_pkg::KW2_W-1:0]               o_kw2,
  output logic [rot_pkg::CIN_W-1:0]               o_cin_1,
  output logic [rot_pkg::COLS_W-1:0]              o_cols_1,
  output logic [rot_pkg::XN_W-1:0]                o_xn_1,
  output logic [ADDR_W-1:0]                       o_addr_max
);
  import rot_pkg::*;

  localparam int GEOM_W = KW2_W + CIN_W + COLS_W + XN_W;

  logic [GEOM_W-1:0] geom_q [2];
  logic [KW2_W:0]    kw_n;
  logic [CIN_W:0]    cin_n;
  logic [31:0]       last_full;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      geom_q[0] <= '0;
      geom_q[1] <= '0;
    end else if (i_wen) begin
      geom_q[i_wbank] <= i_geom;
    end
  end

  assign {o_xn_1, o_cols_1, o_cin_1, o_kw2} = geom_q[i_rbank];

  // kernel entries are (2*kw2+1)*(cin_1+1), stored after the config beats
  assign kw_n       = {o_kw2, 1'b1};
  assign cin_n      = {1'b0, o_cin_1} + 1'b1;
  assign last_full  = 32'(CONFIG_BEATS) + 32'(kw_n) * 32'(cin_n) - 32'd1;
  assign o_addr_max = last_full[ADDR_W-1:0];

  a_set_fits: assert property (@(posedge aclk) disable iff (!aresetn)
    last_full < 32'(DEPTH));

endmodule

`default_nettype wire

/* hdl/weight_bank_ram.sv */
/*
  Two banks of COLS-wide weight words, one write port and one registered read port.
  No reset on the storage or the read register; read data is valid one cycle after i_ren.
*/
`default_nettype none

module weight_bank_ram #(
  parameter  int COLS   = 4,
  parameter  int WORD_W = 8,
  parameter  int DEPTH  = 64,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  wire                     aclk,
  input  wire                     i_wen,
  input  wire                     i_wbank,
  input  wire [ADDR_W-1:0]        i_waddr,
  input  wire [COLS*WORD_W-1:0]   i_wdata,
  input  wire                     i_ren,
  input  wire                     i_rbank,
  input  wire [ADDR_W-1:0]        i_raddr,
  output logic [COLS*WORD_W-1:0]  o_rdata
);

  logic [COLS*WORD_W-1:0] mem [2][DEPTH];

  always_ff @(posedge aclk) begin
    if (i_wen) mem[i_wbank][i_waddr] <= i_wdata;
    // one cycle read
    if (i_ren) o_rdata <= mem[i_rbank][i_raddr];
  end

  // the bank handoff keeps writer and reader on different banks
  a_bank_conflict: assert property (@(posedge aclk)
    !(i_wen && i_ren && (i_wbank == i_rbank)));

endmodule

`default_nettype wire

/* hdl/weight_write_ctrl.sv */
/*
  Write side of the double buffer. Fills the idle bank one beat per handshake.
  A set must fit in DEPTH entries; longer sets wrap the write address.
*/
`default_nettype none

module weight_write_ctrl #(
  parameter  int DEPTH  = 64,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  wire               aclk,
  input  wire               aresetn,
  input  wire               i_s_tvalid,
  input  wire               i_s_tlast,
  output logic              o_s_tready,
  output logic              o_wen,
  output logic [ADDR_W-1:0] o_waddr,
  output logic              o_wbank,
  output logic              o_cfg_wen,
  input  wire               i_read_done,
  input  wire               i_done_bank,
  output logic [1:0]        o_bank_full
);
  import rot_pkg::*;

  wr_state_e state;

  assign o_s_tready = (state == wr_write);
  assign o_wen      = i_s_tvalid && o_s_tready;
  assign o_cfg_wen  = o_wen && i_s_tlast;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= wr_idle;
      o_waddr <= '0;
      o_wbank <= 1'b0;
    end else begin
      unique case (state)
        // wait until the reader has released this bank
        wr_idle: if (!o_bank_full[o_wbank]) state <= wr_write;
        wr_write: begin
          if (o_wen) o_waddr <= o_waddr + 1'b1;
          if (o_cfg_wen) state <= wr_switch;
        end
        wr_switch: begin
          o_waddr <= '0;
          o_wbank <= ~o_wbank;
          state   <= wr_idle;
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // full flags, set by this side and cleared by the reader
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_bank_full <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (state == wr_switch && o_wbank == 1'(b)) o_bank_full[b] <= 1'b1;
        else if (i_read_done && i_done_bank == 1'(b)) o_bank_full[b] <= 1'b0;
      end
    end
  end

  // the reader hands back only a bank that was filled
  a_release_full: assert property (@(posedge aclk) disable iff (!aresetn)
    i_read_done |-> o_bank_full[i_done_bank]);

endmodule

`default_nettype wire

/* hdl/rot_pkg.sv */
/*
  Shared widths, FSM state types and the output tuser layout of the weight rotator.
  i_s_tuser packs the geometry as {xn_1, cols_1, cin_1, kw2} with kw2 in the low bits.
*/
`default_nettype none

package rot_pkg;

  // geometry field widths, same meaning as on i_s_tuser
  parameter int KW2_W  = 2;
  parameter int CIN_W  = 6;
  parameter int COLS_W = 8;
  parameter int XN_W   = 4;

  typedef enum logic [1:0] {
    wr_idle,
    wr_write,
    wr_switch
  } wr_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_pass_config,
    rd_read,
    rd_switch
  } rd_state_e;

  // position flags sent with every output beat
  typedef struct packed {
    logic             is_config;
    logic             is_w_first_clk;
    logic             is_cin_last;
    logic             is_w_first_kw2;
    logic             is_w_last;
    logic [KW2_W-1:0] kw2;
  } weight_user_t;

endpackage

`default_nettype wire
